//--- compile.f
+incdir+tests
verilog/dcache_pkg.sv
verilog/dcache_ram.sv
verilog/dcache_refill.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tests/tb_dcache.sv

//--- Makefile
# Verilator flow for the data cache testbench

TOP := tb_dcache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

# Pass only if the pass line shows up in the simulation output
sim:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

//--- tests/tb_mem_model.svh
// Reference model for the data cache testbench, included inside tb_dcache
// Backing memory that every CPU write updates, plus a shadow tag per set
// that tracks which line the cache is expected to hold
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// Words never written read back as a fill pattern of their address
dcache_pkg::word_t backing [dcache_pkg::adr_t];
logic              shadow_valid [64];
logic [21:0]       shadow_tag [64];

// Every address bit feeds the pattern
function automatic dcache_pkg::word_t fill_word(input dcache_pkg::adr_t adr);
   return adr ^ {adr[24:0], adr[31:25]} ^ 32'h5ac3_96e1;
endfunction

function automatic dcache_pkg::word_t mem_read(input dcache_pkg::adr_t adr);
   if (backing.exists(adr)) begin
      return backing[adr];
   end
   return fill_word(adr);
endfunction

// Byte lanes picked by a widened select mask
function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old,
                                                  input dcache_pkg::word_t wdat,
                                                  input logic [3:0] bsel);
   dcache_pkg::word_t mask;
   mask = {{8{bsel[3]}}, {8{bsel[2]}}, {8{bsel[1]}}, {8{bsel[0]}}};
   return (old & ~mask) | (wdat & mask);
endfunction

// Set index is adr[9:4], tag is adr[31:10]
function automatic logic shadow_hit(input dcache_pkg::adr_t adr);
   return shadow_valid[adr[9:4]] && (shadow_tag[adr[9:4]] == adr[31:10]);
endfunction

// 16 lines, two tags on each of 8 sets
function automatic dcache_pkg::adr_t pick_adr(input logic [3:0] line, input logic [1:0] word);
   logic [21:0] tag;
   tag = line[3] ? 22'h2b5c1 : 22'h01d3a;
   return {tag, line[2:0], 3'b011, word, 2'b00};
endfunction

task automatic clear_model();
   backing.delete();
   for (int s = 0; s < 64; s++) begin
      shadow_valid[s] = 1'b0;
      shadow_tag[s]   = '0;
   end
endtask

`endif

//--- tests/tb_dcache.sv
// Randomized testbench for the direct-mapped data cache
// Drives CPU reads, writes and invalidates over 16 aliasing lines,
// plays the refill memory agent and checks against a reference model
`timescale 1ns/1ps

module tb_dcache;

   localparam int N_TRANS          = 400;
   localparam int CYCLES_PER_TRANS = 40;

   logic                  clk;
   logic                  rst;
   logic                  cpu_req_i;
   dcache_pkg::cpu_req_t  cpu_i;
   logic                  cpu_ack_o;
   dcache_pkg::word_t     cpu_dat_o;
   logic                  inv_i;
   dcache_pkg::adr_t      inv_adr_i;
   logic                  inv_ack_o;
   logic                  refill_req_o;
   dcache_pkg::adr_t      refill_adr_o;
   logic                  refill_done_o;
   logic                  mem_we_i;
   dcache_pkg::mem_beat_t mem_beat_i;

   integer seed;
   int     errors;
   int     checks;
   int     n_reads;
   int     n_writes;
   int     n_invs;
   int     n_refills;

   `include "tb_mem_model.svh"

   dcache_top dut0 (
      .clk           (clk),
      .rst           (rst),
      .cpu_req_i     (cpu_req_i),
      .cpu_i         (cpu_i),
      .cpu_ack_o     (cpu_ack_o),
      .cpu_dat_o     (cpu_dat_o),
      .inv_i         (inv_i),
      .inv_adr_i     (inv_adr_i),
      .inv_ack_o     (inv_ack_o),
      .refill_req_o  (refill_req_o),
      .refill_adr_o  (refill_adr_o),
      .refill_done_o (refill_done_o),
      .mem_we_i      (mem_we_i),
      .mem_beat_i    (mem_beat_i)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   task automatic check_true(input logic cond, input string what);
      checks++;
      assert (cond) else begin
         errors++;
         $display("[ERROR] %0t: %s", $time, what);
      end
   endtask

   // Memory agent playing four beats that wrap from the missed word
   // Up to 3 idle cycles before each beat
   task automatic serve_refill(input dcache_pkg::adr_t adr);
      int         gap;
      logic [1:0] w;
      for (int i = 0; i < 4; i++) begin
         gap = $random(seed) & 3;
         w   = adr[3:2] + i[1:0];
         repeat (gap) begin
            @(posedge clk);
            #1;
            mem_we_i = 1'b0;
         end
         @(posedge clk);
         #1;
         mem_we_i       = 1'b1;
         mem_beat_i.adr = {adr[31:4], w, 2'b00};
         mem_beat_i.dat = mem_read({adr[31:4], w, 2'b00});
         // Done only with the beat that completes the line
         @(negedge clk);
         check_true(refill_done_o == (i == 3),
                    $sformatf("refill_done_o %b on beat %0d", refill_done_o, i));
      end
      @(posedge clk);
      #1;
      mem_we_i   = 1'b0;
      mem_beat_i = '0;
      n_refills++;
   endtask

   // One CPU access started 1 ns after a rising edge with the DUT in IDLE
   task automatic cpu_access(input logic we, input dcache_pkg::adr_t adr,
                             input dcache_pkg::word_t dat, input logic [3:0] bsel);
      int   lat;
      logic expect_hit;
      logic saw_refill;
      logic got_ack;
      expect_hit = shadow_hit(adr);
      saw_refill = 1'b0;
      got_ack    = 1'b0;
      lat        = 0;
      cpu_req_i  = 1'b1;
      cpu_i.we   = we;
      cpu_i.adr  = adr;
      cpu_i.dat  = dat;
      cpu_i.bsel = bsel;
      while (!got_ack) begin
         @(negedge clk);
         lat++;
         if (cpu_ack_o) begin
            got_ack = 1'b1;
         end else if (refill_req_o && !saw_refill) begin
            saw_refill = 1'b1;
            check_true(refill_adr_o == adr,
                       $sformatf("refill_adr_o %h, expected %h", refill_adr_o, adr));
            serve_refill(adr);
            shadow_valid[adr[9:4]] = 1'b1;
            shadow_tag[adr[9:4]]   = adr[31:10];
            // DUT is back in IDLE and sees the held request again
            lat = 0;
         end
      end
      // Only a read to a set holding another line refills
      check_true(saw_refill == (!we && !expect_hit),
                 $sformatf("access %h we %b refill %b, expected hit %b",
                           adr, we, saw_refill, expect_hit));
      // Every ack comes 2 cycles after the request is seen in IDLE
      check_true(lat == 2, $sformatf("access %h acked after %0d cycles", adr, lat));
      if (we) begin
         backing[adr] = merge_bytes(mem_read(adr), dat, bsel);
         n_writes++;
      end else begin
         check_true(cpu_dat_o == mem_read(adr),
                    $sformatf("read %h returned %h, expected %h",
                              adr, cpu_dat_o, mem_read(adr)));
         n_reads++;
      end
      @(posedge clk);
      #1;
      cpu_req_i = 1'b0;
   endtask

   task automatic cache_invalidate(input dcache_pkg::adr_t adr);
      int lat;
      lat       = 0;
      inv_i     = 1'b1;
      inv_adr_i = adr;
      do begin
         @(negedge clk);
         lat++;
      end while (!inv_ack_o);
      // Accepted at the first edge and acked in the cycle after
      check_true(lat == 2, $sformatf("invalidate %h acked after %0d cycles", adr, lat));
      shadow_valid[adr[9:4]] = 1'b0;
      n_invs++;
      @(posedge clk);
      #1;
      inv_i = 1'b0;
   endtask

   initial begin
      logic [31:0]      r;
      dcache_pkg::adr_t adr;
      seed       = 32'ha1d6a3f5;
      errors     = 0;
      checks     = 0;
      n_reads    = 0;
      n_writes   = 0;
      n_invs     = 0;
      n_refills  = 0;
      clk        = 1'b0;
      rst        = 1'b1;
      cpu_req_i  = 1'b0;
      cpu_i      = '0;
      inv_i      = 1'b0;
      inv_adr_i  = '0;
      mem_we_i   = 1'b0;
      mem_beat_i = '0;
      clear_model();
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      check_true(!(cpu_ack_o || refill_req_o || refill_done_o || inv_ack_o),
                 "control output high after reset");
      @(posedge clk);
      #1;
      // Tag RAM comes up unknown so all sets are cleared before any request
      for (int s = 0; s < 64; s++) begin
         cache_invalidate({22'h0, s[5:0], 4'h0});
      end
      for (int t = 0; t < N_TRANS; t++) begin
         r   = $random(seed);
         adr = pick_adr(r[3:0], r[5:4]);
         if (r[9:6] < 4'd7) begin
            cpu_access(1'b0, adr, '0, 4'h0);
         end else if (r[9:6] < 4'd14) begin
            cpu_access(1'b1, adr, $random(seed), r[13:10]);
            // Read back shows the merge on a hit and a refill on a miss
            if (r[14]) begin
               cpu_access(1'b0, adr, '0, 4'h0);
            end
         end else begin
            cache_invalidate(adr);
            if (r[14]) begin
               cpu_access(1'b0, adr, '0, 4'h0);
            end
         end
      end
      $display("reads %0d writes %0d invalidates %0d refills %0d checks %0d errors %0d",
               n_reads, n_writes, n_invs, n_refills, checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // Watchdog sized from the transaction count
   initial begin
      repeat (N_TRANS * CYCLES_PER_TRANS) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", N_TRANS * CYCLES_PER_TRANS);
      $display("sim failed");
      $finish;
   end

endmodule

//--- verilog/dcache_top.sv
// Top level of the direct-mapped data cache
// Connects the controller, the refill sequencer and the tag and data RAMs
// CPU side holds req until cpu_ack_o, memory side feeds refill beats
`timescale 1ns/1ps

module dcache_top (
   input  logic                  clk,
   input  logic                  rst,
   // CPU side
   input  logic                  cpu_req_i,
   input  dcache_pkg::cpu_req_t  cpu_i,
   output logic                  cpu_ack_o,
   output dcache_pkg::word_t     cpu_dat_o,
   // Invalidate
   input  logic                  inv_i,
   input  dcache_pkg::adr_t      inv_adr_i,
   output logic                  inv_ack_o,
   // Memory side
   output logic                  refill_req_o,
   output dcache_pkg::adr_t      refill_adr_o,
   output logic                  refill_done_o,
   input  logic                  mem_we_i,
   input  dcache_pkg::mem_beat_t mem_beat_i
);

   dcache_pkg::tag_entry_t tag_dout;
   dcache_pkg::word_t      data_dout;
   dcache_pkg::tag_wr_t    ctrl_tag_wr;
   dcache_pkg::tag_wr_t    seq_tag_wr;
   dcache_pkg::tag_wr_t    tag_wr;
   dcache_pkg::data_wr_t   ctrl_data_wr;
   dcache_pkg::data_wr_t   seq_data_wr;
   dcache_pkg::data_wr_t   data_wr;
   logic                   refill_start;

   // Only one writer is active, idle writers drive zero
   assign tag_wr  = ctrl_tag_wr | seq_tag_wr;
   assign data_wr = ctrl_data_wr | seq_data_wr;

   dcache_ctrl ctrl0 (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req_i),
      .cpu_i          (cpu_i),
      .tag_i          (tag_dout),
      .data_i         (data_dout),
      .inv_i          (inv_i),
      .inv_adr_i      (inv_adr_i),
      .refill_done_i  (refill_done_o),
      .cpu_ack_o      (cpu_ack_o),
      .cpu_dat_o      (cpu_dat_o),
      .refill_req_o   (refill_req_o),
      .refill_start_o (refill_start),
      .miss_adr_o     (refill_adr_o),
      .inv_ack_o      (inv_ack_o),
      .tag_wr_o       (ctrl_tag_wr),
      .data_wr_o      (ctrl_data_wr)
   );

   dcache_refill refill0 (
      .clk        (clk),
      .rst        (rst),
      .start_i    (refill_start),
      .miss_adr_i (refill_adr_o),
      .mem_we_i   (mem_we_i),
      .mem_beat_i (mem_beat_i),
      .tag_wr_o   (seq_tag_wr),
      .data_wr_o  (seq_data_wr),
      .done_o     (refill_done_o)
   );

   // Both RAMs are read at the current CPU address every cycle
   dcache_ram #(
      .payload_t (dcache_pkg::tag_entry_t),
      .DEPTH     (1 << dcache_pkg::SET_WIDTH)
   ) tag_ram (
      .clk     (clk),
      .we_i    (tag_wr.we),
      .waddr_i (tag_wr.index),
      .din_i   (tag_wr.entry),
      .raddr_i (dcache_pkg::index_of(cpu_i.adr)),
      .dout_o  (tag_dout)
   );

   dcache_ram #(
      .payload_t (dcache_pkg::word_t),
      .DEPTH     (1 << (dcache_pkg::WAY_WIDTH - 2))
   ) data_ram (
      .clk     (clk),
      .we_i    (data_wr.we),
      .waddr_i (data_wr.addr),
      .din_i   (data_wr.dat),
      .raddr_i (dcache_pkg::word_addr_of(cpu_i.adr)),
      .dout_o  (data_dout)
   );

endmodule

//--- verilog/dcache_ctrl.sv
// Data cache controller
// Looks up the held CPU request against the tag and data RAM outputs,
// acknowledges hits and writes, merges write-hit data, starts refills
// on read misses and clears sets on invalidate
`timescale 1ns/1ps

module dcache_ctrl (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cpu_req_i,
   input  dcache_pkg::cpu_req_t cpu_i,
   input  dcache_pkg::tag_entry_t tag_i,
   input  dcache_pkg::word_t    data_i,
   input  logic                 inv_i,
   input  dcache_pkg::adr_t     inv_adr_i,
   input  logic                 refill_done_i,
   output logic                 cpu_ack_o,
   output dcache_pkg::word_t    cpu_dat_o,
   output logic                 refill_req_o,
   output logic                 refill_start_o,
   output dcache_pkg::adr_t     miss_adr_o,
   output logic                 inv_ack_o,
   output dcache_pkg::tag_wr_t  tag_wr_o,
   output dcache_pkg::data_wr_t data_wr_o
);

   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      REFILL,
      INVALIDATE
   } state_t;

   state_t state;
   state_t state_next;

   // Tag compare result for the request in LOOKUP
   logic hit;
   logic lookup;
   logic read_miss;
   // Stored word with the selected bytes replaced by write data
   dcache_pkg::word_t merged;
   // Set picked up when an invalidate is accepted
   logic [dcache_pkg::SET_WIDTH-1:0] inv_idx;
   dcache_pkg::adr_t miss_adr;

   // RAM outputs in LOOKUP belong to the request seen in IDLE
   assign hit       = tag_i.valid && (tag_i.tag == dcache_pkg::tag_of(cpu_i.adr));
   assign lookup    = (state == LOOKUP);
   assign read_miss = lookup && !cpu_i.we && !hit;

   // Writes are always acked and a write miss leaves the cache alone
   assign cpu_ack_o      = lookup && (cpu_i.we || hit);
   assign cpu_dat_o      = data_i;
   assign refill_req_o   = (state == REFILL);
   // Arms the sequencer one cycle before beats may arrive
   assign refill_start_o = read_miss;
   assign miss_adr_o     = miss_adr;
   assign inv_ack_o      = (state == INVALIDATE);

   // Byte merge
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged[8*b +: 8] = cpu_i.bsel[b] ? cpu_i.dat[8*b +: 8] : data_i[8*b +: 8];
      end
   end

   // Next state
   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            // Invalidate wins over a pending CPU request
            if (inv_i) begin
               state_next = INVALIDATE;
            end else if (cpu_req_i) begin
               state_next = LOOKUP;
            end
         end
         LOOKUP: begin
            if (read_miss) begin
               state_next = REFILL;
            end else begin
               state_next = IDLE;
            end
         end
         REFILL: begin
            // Back to IDLE where the held request is looked up again and hits
            if (refill_done_i) begin
               state_next = IDLE;
            end
         end
         INVALIDATE: begin
            state_next = IDLE;
         end
         default: begin
            state_next = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

   // Held addresses
   always_ff @(posedge clk) begin
      if (state == IDLE && inv_i) begin
         inv_idx <= dcache_pkg::index_of(inv_adr_i);
      end
      if (read_miss) begin
         miss_adr <= cpu_i.adr;
      end
   end

   // RAM writes owned by the controller are zero when idle
   always_comb begin
      tag_wr_o  = '0;
      data_wr_o = '0;
      if (state == INVALIDATE) begin
         // Entry cleared with valid and tag both zero
         tag_wr_o.we    = 1'b1;
         tag_wr_o.index = inv_idx;
      end
      if (lookup && cpu_i.we && hit) begin
         data_wr_o.we   = 1'b1;
         data_wr_o.addr = dcache_pkg::word_addr_of(cpu_i.adr);
         data_wr_o.dat  = merged;
      end
   end

   // CPU is answered only once no refill is outstanding
   a_ack_not_refill: assert property (@(posedge clk) disable iff (rst)
      !(cpu_ack_o && refill_req_o));

   // Sequencer finishes only inside REFILL so its RAM writes never
   // overlap the controller's own writes
   a_done_in_refill: assert property (@(posedge clk) disable iff (rst)
      refill_done_i |-> (state == REFILL));

endmodule

//--- verilog/dcache_refill.sv
// Refill sequencer for the data cache
// Armed by a start pulse from the controller, then turns memory beats
// into data RAM writes and brackets the line with two tag writes
// First beat invalidates the set, the completing beat makes it valid
`timescale 1ns/1ps

module dcache_refill (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start_i,
   input  dcache_pkg::adr_t      miss_adr_i,
   input  logic                  mem_we_i,
   input  dcache_pkg::mem_beat_t mem_beat_i,
   output dcache_pkg::tag_wr_t   tag_wr_o,
   output dcache_pkg::data_wr_t  data_wr_o,
   output logic                  done_o
);

   // Refill in progress
   logic active;
   // Words of the line received so far
   logic [dcache_pkg::WORDS_PER_LINE-1:0] rcvd;
   logic [dcache_pkg::WORDS_PER_LINE-1:0] rcvd_next;
   // Word position of the current beat
   logic [dcache_pkg::WORD_SEL_WIDTH-1:0] beat_sel;
   logic first_beat;
   logic last_beat;

   assign beat_sel   = mem_beat_i.adr[dcache_pkg::BLOCK_WIDTH-1:2];
   assign rcvd_next  = rcvd | (dcache_pkg::WORDS_PER_LINE'(1) << beat_sel);
   assign first_beat = (rcvd == '0);
   // Beats may arrive in any wrap order, so completion is a full mask
   assign last_beat  = (rcvd_next == '1);
   assign done_o     = mem_we_i && last_beat;

   always_ff @(posedge clk) begin
      if (rst) begin
         active <= 1'b0;
         rcvd   <= '0;
      end else if (start_i) begin
         active <= 1'b1;
         rcvd   <= '0;
      end else if (mem_we_i) begin
         rcvd <= rcvd_next;
         if (last_beat) begin
            active <= 1'b0;
         end
      end
   end

   // Write requests, all zero when no beat so the top can OR them
   always_comb begin
      tag_wr_o  = '0;
      data_wr_o = '0;
      if (mem_we_i) begin
         data_wr_o.we   = 1'b1;
         data_wr_o.addr = dcache_pkg::word_addr_of(mem_beat_i.adr);
         data_wr_o.dat  = mem_beat_i.dat;
         if (first_beat || last_beat) begin
            tag_wr_o.we    = 1'b1;
            tag_wr_o.index = dcache_pkg::index_of(miss_adr_i);
            // Invalid on the first beat, valid with the miss tag on the last
            tag_wr_o.entry.valid = last_beat;
            tag_wr_o.entry.tag   = last_beat ? dcache_pkg::tag_of(miss_adr_i) : '0;
         end
      end
   end

   // Agent must only send beats after the controller armed a refill
   a_beat_in_refill: assert property (@(posedge clk) disable iff (rst)
      mem_we_i |-> active);

   // Every beat belongs to the line that missed
   a_beat_line: assert property (@(posedge clk) disable iff (rst)
      mem_we_i |-> (mem_beat_i.adr[31:dcache_pkg::BLOCK_WIDTH] ==
                    miss_adr_i[31:dcache_pkg::BLOCK_WIDTH]));

endmodule

//--- verilog/dcache_ram.sv
// Single-clock dual-port RAM used for both cache tags and cache data
// One synchronous write port, one read port with a registered output
// Payload type and depth are set per instance
`timescale 1ns/1ps

module dcache_ram #(
   parameter type payload_t = dcache_pkg::word_t,
   parameter int  DEPTH     = 64
) (
   input  logic                     clk,
   input  logic                     we_i,
   input  logic [$clog2(DEPTH)-1:0] waddr_i,
   input  payload_t                 din_i,
   input  logic [$clog2(DEPTH)-1:0] raddr_i,
   output payload_t                 dout_o
);

   // Storage array, contents undefined until written
   payload_t mem [DEPTH];

   // Write port
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
   end

   // Read port, one cycle latency
   // Same-address write in the same cycle is forwarded to the output
   always_ff @(posedge clk) begin
      if (we_i && (waddr_i == raddr_i)) begin
         dout_o <= din_i;
      end else begin
         dout_o <= mem[raddr_i];
      end
   end

endmodule

//--- verilog/dcache_pkg.sv
// Shared definitions for the direct-mapped data cache
// Geometry constants, packed request and write structs, address slicing helpers
// Every RTL file refers to these by scoped name
package dcache_pkg;

   // Line of 16 bytes, 64 sets
   localparam int BLOCK_WIDTH    = 4;
   localparam int SET_WIDTH      = 6;
   // Byte span covered by the whole cache
   localparam int WAY_WIDTH      = BLOCK_WIDTH + SET_WIDTH;
   localparam int TAG_WIDTH      = 32 - WAY_WIDTH;
   localparam int WORDS_PER_LINE = 4;
   localparam int WORD_SEL_WIDTH = 2;

   typedef logic [31:0] word_t;
   typedef logic [31:0] adr_t;

   // One tag RAM entry
   typedef struct packed {
      logic                 valid;
      logic [TAG_WIDTH-1:0] tag;
   } tag_entry_t;

   // CPU request, held stable until acknowledged
   typedef struct packed {
      logic       we;
      adr_t       adr;
      word_t      dat;
      logic [3:0] bsel;
   } cpu_req_t;

   // Refill beat from the memory agent, qualified by a separate strobe
   typedef struct packed {
      adr_t  adr;
      word_t dat;
   } mem_beat_t;

   // Tag RAM write request, all zero when idle so writers can be ORed
   typedef struct packed {
      logic                 we;
      logic [SET_WIDTH-1:0] index;
      tag_entry_t           entry;
   } tag_wr_t;

   // Data RAM write request, same zero-when-idle convention
   typedef struct packed {
      logic                   we;
      logic [WAY_WIDTH-3:0]   addr;
      word_t                  dat;
   } data_wr_t;

   // Set index of a byte address
   function automatic logic [SET_WIDTH-1:0] index_of(adr_t adr);
      return adr[WAY_WIDTH-1:BLOCK_WIDTH];
   endfunction

   // Tag bits left of the index
   function automatic logic [TAG_WIDTH-1:0] tag_of(adr_t adr);
      return adr[31:WAY_WIDTH];
   endfunction

   // Word address inside the data RAM
   function automatic logic [WAY_WIDTH-3:0] word_addr_of(adr_t adr);
      return adr[WAY_WIDTH-1:2];
   endfunction

endpackage
